//--- bench/coreHarnessTb.sv
// ----------------------------------------------------------------------
// Testbench for the host link harness. Random downstream words from an
// xorshift source, checked against a register and upstream queue model
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`include "harness_macros.svh"

module coreHarnessTb;
  import harnessPkg::*;

  localparam int ResetCycles   = 10;
  localparam int RandWords     = 400;   // Decoder phase
  localparam int ChanRunCycles = 3000;  // Timers running
  localparam int QuietCycles   = 300;   // Longer than the largest period
  localparam int BurstWords    = 70;    // More than the FIFO holds
  localparam int StimCycles    = ResetCycles + RandWords + ChanRunCycles + QuietCycles +
                                 BurstWords + 4 * `UP_FIFO_DEPTH + 50;
  localparam int TimeoutCycles = 4 * StimCycles;

  logic      okClk;
  logic      rstN;
  logic      pipeInValid;
  hostWordT  pipeInData;
  logic      pipeOutRead;
  hostWordT  pipeOutData;
  logic      pipeOutEmpty;
  logic      bdValid;
  bdCodeT    bdCode;
  bdPayloadT bdPayload;
  logic [3:0] led;
  logic      upOverflow;

  // ----------------------------------------------------------------------
  // Model state
  // ----------------------------------------------------------------------
  regDataT   modelRegs [`NUM_REGS];
  hostWordT  expQ [$];          // Decoder-path words still due upstream
  logic      expBdValid;        // To-chip strobe due after this edge
  bdCodeT    expCode;
  bdPayloadT expPayload;
  logic      expOverflow;
  regDataT   lastCount [`NUM_CHAN];
  int        reportCount [`NUM_CHAN];
  logic      quietCheck;        // Set while every timer should be silent
  logic [31:0] rngState;
  int        valueErrors;
  int        otherErrors;
  int        cycles;

  coreHarness DUT (
    .okClk        (okClk),
    .rstN         (rstN),
    .pipeInValid  (pipeInValid),
    .pipeInData   (pipeInData),
    .pipeOutRead  (pipeOutRead),
    .pipeOutData  (pipeOutData),
    .pipeOutEmpty (pipeOutEmpty),
    .bdValid      (bdValid),
    .bdCode       (bdCode),
    .bdPayload    (bdPayload),
    .led          (led),
    .upOverflow   (upOverflow)
  );

  initial okClk = 1'b0;
  always #20 okClk = ~okClk;  // 40 ns period

  always @(posedge okClk) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the run never reached its end", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Word builders, field layout from the host protocol
  function automatic hostWordT bdWord(bdCodeT code, bdPayloadT payload);
    return {2'b00, code, 4'h0, payload};
  endfunction

  function automatic hostWordT cfgWord(logic [1:0] kindBits, regIdT id, regDataT data);
    return {kindBits, 1'b0, id, 8'h00, data};  // Register and channel writes
  endfunction

  // ----------------------------------------------------------------------
  // Upstream checks, sampled at the falling edge before the pop
  // ----------------------------------------------------------------------
  task automatic checkReport(input hostWordT w);
    int ch;
    ch = int'(w[28:24]);
    assert (w[29] == 1'b0 && w[23:16] == 8'h00 && ch < `NUM_CHAN) else begin
      valueErrors++;
      $display("Fail %0t: malformed channel report %h", $time, w);
    end
    assert (!quietCheck) else begin
      otherErrors++;
      $display("Channel %0d sent a report after it was stopped", ch);
    end
    if (ch < `NUM_CHAN) begin
      assert (w[15:0] > lastCount[ch]) else begin
        valueErrors++;
        $display("Fail %0t: channel %0d count %0d not above %0d", $time, ch,
                 w[15:0], lastCount[ch]);
      end
      lastCount[ch] = w[15:0];
      reportCount[ch]++;
    end
  endtask

  task automatic checkUpWord(input hostWordT w);
    hostWordT e;
    assert (expQ.size() > 0) else begin
      otherErrors++;
      $display("Upstream word %h arrived while none was expected", w);
    end
    if (expQ.size() > 0) begin
      e = expQ.pop_front();
      assert (w == e) else begin
        valueErrors++;
        $display("Fail %0t: upstream word %h, expected %h", $time, w, e);
      end
    end
  endtask

  always @(negedge okClk) begin
    if (rstN && pipeOutRead && !pipeOutEmpty) begin
      // Kind 11 without the ff tag is a timer report
      if (pipeOutData[31:30] == 2'b11 && pipeOutData[31:24] != 8'hff) begin
        checkReport(pipeOutData);
      end else begin
        checkUpWord(pipeOutData);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus, one call per clock cycle
  // ----------------------------------------------------------------------
  task automatic stepCycle(input logic v, input wordKindE k, input hostWordT w);
    @(posedge okClk);
    #1;
    // Outputs of the word driven one cycle ago
    assert (bdValid == expBdValid) else begin
      valueErrors++;
      $display("Fail %0t: bdValid %b, expected %b", $time, bdValid, expBdValid);
    end
    if (expBdValid && bdValid) begin
      assert (bdCode == expCode && bdPayload == expPayload) else begin
        valueErrors++;
        $display("Fail %0t: bd message %h/%h, expected %h/%h", $time, bdCode,
                 bdPayload, expCode, expPayload);
      end
    end
    assert (led == modelRegs[0][3:0]) else begin
      valueErrors++;
      $display("Fail %0t: led %h, expected %h", $time, led, modelRegs[0][3:0]);
    end
    pipeInValid = v;
    pipeInData  = w;
    expBdValid  = v && (k == KindBd);
    expCode     = w[29:24];
    expPayload  = w[19:0];
    if (v && k == KindReg && w[28:24] != 5'd`NOP_REG) modelRegs[int'(w[28:24])] = w[15:0];
    if (v && (k == KindFromBd || (k == KindBd && modelRegs[1][0]))) begin
      // Without reads the FIFO holds exactly the first words
      if (!pipeOutRead && expQ.size() >= `UP_FIFO_DEPTH) begin
        expOverflow = 1'b1;
      end else begin
        expQ.push_back(w);
      end
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) stepCycle(1'b0, KindBd, '0);
  endtask

  task automatic sendRandom();
    logic [31:0] sel;
    logic [31:0] data;
    sel  = nextRand();
    data = nextRand();
    case (sel % 32'd10)
      0, 1, 2, 3: stepCycle(1'b1, KindBd, bdWord(data[31:26], data[19:0]));
      4, 5:       stepCycle(1'b1, KindFromBd, {8'hff, data[23:0]});
      6:          stepCycle(1'b1, KindReg, cfgWord(2'b10, regIdT'(sel[8]), data[15:0]));
      7:          stepCycle(1'b1, KindReg, cfgWord(2'b10, sel[9] ? 5'd31 :
                            regIdT'(2 + sel[15:8] % 29), data[15:0]));
      default:    idleCycles(1);
    endcase
  endtask

  // Idle until every expected word has left the FIFO
  task automatic drainAll();
    idleCycles(4);
    while (expQ.size() != 0 || !pipeOutEmpty) idleCycles(1);
  endtask

  initial begin
    rngState    = 32'd55;
    rstN        = 1'b0;
    pipeInValid = 1'b0;
    pipeInData  = '0;
    pipeOutRead = 1'b0;
    expBdValid  = 1'b0;
    expCode     = '0;
    expPayload  = '0;
    expOverflow = 1'b0;
    quietCheck  = 1'b0;
    valueErrors = 0;
    otherErrors = 0;
    cycles      = 0;
    for (int i = 0; i < `NUM_REGS; i++) modelRegs[i] = '0;
    for (int i = 0; i < `NUM_CHAN; i++) begin
      lastCount[i]   = '0;
      reportCount[i] = 0;
    end
    repeat (ResetCycles) @(posedge okClk);
    #1;
    rstN        = 1'b1;
    pipeOutRead = 1'b1;  // Host drains continuously

    // LEDs, then a no-op write that must not reach register 0 or 1
    stepCycle(1'b1, KindReg, cfgWord(2'b10, 5'd0, 16'h0005));
    stepCycle(1'b1, KindReg, cfgWord(2'b10, 5'd31, 16'hffff));
    stepCycle(1'b1, KindBd, bdWord(6'h2a, 20'h12345));
    idleCycles(2);

    // Mixed to-chip, from-chip and register traffic
    repeat (RandWords) sendRandom();
    drainAll();

    // All timers running with light decoder traffic on top
    for (int ch = 0; ch < `NUM_CHAN; ch++) begin
      stepCycle(1'b1, KindChan, cfgWord(2'b11, regIdT'(ch), regDataT'(20 + nextRand() % 181)));
    end
    for (int i = 0; i < ChanRunCycles; i++) begin
      if (nextRand() % 32'd8 == 0) begin
        sendRandom();
      end else begin
        idleCycles(1);
      end
    end
    for (int ch = 0; ch < `NUM_CHAN; ch++) begin
      stepCycle(1'b1, KindChan, cfgWord(2'b11, regIdT'(ch), 16'h0000));
    end
    idleCycles(10);
    quietCheck = 1'b1;
    idleCycles(QuietCycles);
    quietCheck = 1'b0;
    drainAll();
    for (int ch = 0; ch < `NUM_CHAN; ch++) begin
      assert (reportCount[ch] >= 2) else begin
        otherErrors++;
        $display("Channel %0d sent only %0d reports", ch, reportCount[ch]);
      end
    end
    assert (!upOverflow) else begin
      valueErrors++;
      $display("Fail %0t: upOverflow set without a full FIFO", $time);
    end

    // Echoed burst into a FIFO nobody reads
    stepCycle(1'b1, KindReg, cfgWord(2'b10, 5'd1, 16'h0001));
    pipeOutRead = 1'b0;
    for (int i = 0; i < BurstWords; i++) begin
      stepCycle(1'b1, KindBd, bdWord(6'(i), 20'(nextRand())));
    end
    idleCycles(3);
    assert (upOverflow == expOverflow && expOverflow) else begin
      valueErrors++;
      $display("Fail %0t: upOverflow %b after the burst, expected 1", $time, upOverflow);
    end
    pipeOutRead = 1'b1;
    drainAll();
    assert (upOverflow) else begin
      valueErrors++;
      $display("Fail %0t: upOverflow cleared by draining", $time);
    end

    $display("Checks done, %0d value errors, %0d other errors", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- bench/coreHarness_assertions.sv
// ----------------------------------------------------------------------
// Protocol checks on the harness top-level ports, attached by bind
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module coreHarness_assertions (
  input logic okClk,
  input logic rstN,
  input logic pipeInValid,
  input logic bdValid,
  input logic pipeOutEmpty,
  input logic upOverflow
);

  // To-chip strobe only follows a pipe-in word
  bdNeedsInput: assert property (@(posedge okClk) disable iff (!rstN)
    bdValid |-> $past(pipeInValid))
    else $error("bdValid high without a pipe-in word one cycle earlier");

  // Outputs settle to their idle values after a reset edge
  resetState: assert property (@(posedge okClk)
    !rstN |=> (pipeOutEmpty && !upOverflow && !bdValid))
    else $error("Outputs not at idle values after reset");

  // Overflow flag is sticky
  overflowSticky: assert property (@(posedge okClk) disable iff (!rstN)
    $past(rstN) |-> !$fell(upOverflow))
    else $error("upOverflow fell while out of reset");

endmodule

bind coreHarness coreHarness_assertions uChecks (
  .okClk        (okClk),
  .rstN         (rstN),
  .pipeInValid  (pipeInValid),
  .bdValid      (bdValid),
  .pipeOutEmpty (pipeOutEmpty),
  .upOverflow   (upOverflow)
);

//--- build.f
+incdir+verilog
verilog/harnessPkg.sv
verilog/cmdIf.sv
verilog/hostCommandUnit.sv
verilog/chanTimer.sv
verilog/upstreamMerger.sv
verilog/coreHarness.sv
bench/coreHarness_assertions.sv
bench/coreHarnessTb.sv

//--- runSim.sh
#!/bin/sh
# Build the host link harness testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f \
  --top-module coreHarnessTb \
  -o simv

./obj_dir/simv | tee sim.log

if grep -q "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi

//--- verilog/chanTimer.sv
// ---------------------------------------------------------------------
// Periodic channel timer. Counts periods and holds one report word
// for the upstream merger until it is acknowledged
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module chanTimer #(
  parameter int ChanIndex = 0  // Channel id this timer answers to
) (
  input  logic                 okClk,
  input  logic                 rstN,
  cmdIf.chan                   cmd,
  input  logic                 reportAck,
  output logic                 reportValid,
  output harnessPkg::hostWordT reportWord
);
  import harnessPkg::*;

  regDataT period;     // Cycles per tick, 0 means stopped
  regDataT cycleCnt;   // Position inside the current period
  regDataT tickCnt;    // Completed periods since the last restart
  logic    myWrite;    // Channel write addressed here
  logic    periodEnd;  // Last cycle of a period

  assign myWrite   = cmd.chanWrite && (cmd.chanId == regIdT'(ChanIndex));
  assign periodEnd = (period != '0) && (cycleCnt == regDataT'(period - 16'd1));

  // Report always carries the latest count, so a refresh is free
  assign reportWord = {2'(KindChan), 1'b0, regIdT'(ChanIndex), 8'h00, tickCnt};

  always_ff @(posedge okClk) begin
    if (!rstN) begin
      period      <= '0;
      cycleCnt    <= '0;
      tickCnt     <= '0;
      reportValid <= 1'b0;
    end else if (myWrite) begin
      period      <= cmd.chanValue;  // Restart, or stop on zero
      cycleCnt    <= '0;
      tickCnt     <= '0;
      reportValid <= 1'b0;           // Pending report is dropped
    end else if (period != '0) begin
      if (reportAck) reportValid <= 1'b0;
      if (periodEnd) begin
        cycleCnt    <= '0;
        tickCnt     <= tickCnt + 16'd1;
        reportValid <= 1'b1;         // New tick wins over a same-cycle ack
      end else begin
        cycleCnt <= cycleCnt + 16'd1;
      end
    end
  end

endmodule

//--- verilog/cmdIf.sv
// ---------------------------------------------------------------------
// Channel write bus from the command decoder to the channel timers
// ---------------------------------------------------------------------

`timescale 1ns/1ps

interface cmdIf;
  import harnessPkg::*;

  logic    chanWrite;  // One cycle strobe per channel word
  regIdT   chanId;     // Addressed channel
  regDataT chanValue;  // New period, 0 stops the timer

  // Decoder side
  modport cmd (
    output chanWrite,
    output chanId,
    output chanValue
  );

  // Timer side, each timer filters on its own id
  modport chan (
    input chanWrite,
    input chanId,
    input chanValue
  );

endinterface

//--- verilog/coreHarness.sv
// ---------------------------------------------------------------------
// Host link harness top level. Connects the decoder, the channel
// timers and the upstream merger to plain host and chip ports
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`include "harness_macros.svh"

module coreHarness (
  input  logic                  okClk,
  input  logic                  rstN,
  // Downstream pipe from the host
  input  logic                  pipeInValid,
  input  harnessPkg::hostWordT  pipeInData,
  // Upstream pipe to the host
  input  logic                  pipeOutRead,
  output harnessPkg::hostWordT  pipeOutData,
  output logic                  pipeOutEmpty,
  // To-chip messages
  output logic                  bdValid,
  output harnessPkg::bdCodeT    bdCode,
  output harnessPkg::bdPayloadT bdPayload,
  // Status
  output logic [3:0]            led,
  output logic                  upOverflow
);
  import harnessPkg::*;

  logic                 upValid;      // Decoder word for the FIFO
  hostWordT             upWord;
  logic [`NUM_CHAN-1:0] reportValid;  // One pending report per channel
  logic [`NUM_CHAN-1:0] reportAck;
  hostWordT             reportWord [`NUM_CHAN];

  cmdIf chanBus ();  // Channel writes, decoder to timers

  hostCommandUnit uCmd (
    .okClk       (okClk),
    .rstN        (rstN),
    .pipeInValid (pipeInValid),
    .pipeInData  (pipeInData),
    .bdValid     (bdValid),
    .bdCode      (bdCode),
    .bdPayload   (bdPayload),
    .upValid     (upValid),
    .upWord      (upWord),
    .led         (led),
    .cmd         (chanBus)
  );

  // ---------------------------------------------------------------------
  // One timer per channel id
  // ---------------------------------------------------------------------
  for (genvar i = 0; i < `NUM_CHAN; i++) begin : gChan
    chanTimer #(
      .ChanIndex (i)
    ) uTimer (
      .okClk       (okClk),
      .rstN        (rstN),
      .cmd         (chanBus),
      .reportAck   (reportAck[i]),
      .reportValid (reportValid[i]),
      .reportWord  (reportWord[i])
    );
  end

  upstreamMerger uMerge (
    .okClk        (okClk),
    .rstN         (rstN),
    .upValid      (upValid),
    .upWord       (upWord),
    .reportValid  (reportValid),
    .reportWord   (reportWord),
    .reportAck    (reportAck),
    .pipeOutRead  (pipeOutRead),
    .pipeOutData  (pipeOutData),
    .pipeOutEmpty (pipeOutEmpty),
    .upOverflow   (upOverflow)
  );

endmodule

//--- verilog/harnessPkg.sv
// ---------------------------------------------------------------------
// Shared types for the host link harness and its testbench
// ---------------------------------------------------------------------

`include "harness_macros.svh"

package harnessPkg;

  // ---------------------------------------------------------------------
  // Field types
  // ---------------------------------------------------------------------
  typedef logic [`WORD_W-1:0] hostWordT;   // One host word, up or down
  typedef logic [4:0]         regIdT;      // Register or channel id
  typedef logic [15:0]        regDataT;    // Register, period or count value
  typedef logic [5:0]         bdCodeT;     // To-chip message code
  typedef logic [19:0]        bdPayloadT;  // To-chip message payload

  // Top two bits of a downstream word select its kind
  typedef enum logic [1:0] {
    KindBd     = 2'b00,  // Message to the chip
    KindFromBd = 2'b01,  // Injected chip traffic, host sends it with tag ff
    KindReg    = 2'b10,  // Configuration register write
    KindChan   = 2'b11   // Channel timer write
  } wordKindE;

  // Full top byte of an injected from-chip word
  localparam logic [7:0] FromBdTag = 8'hff;

  // Classify a downstream word
  // The ff tag overlaps the channel kind code so it is tested first
  function automatic wordKindE kindOf(hostWordT w);
    wordKindE k;
    if (w[`WORD_W-1 -: 8] == FromBdTag) begin
      k = KindFromBd;
    end else begin
      k = wordKindE'(w[`WORD_W-1 -: 2]);
    end
    return k;
  endfunction

endpackage

//--- verilog/harness_macros.svh
// ---------------------------------------------------------------------
// Size constants for the host link harness. Include this file wherever
// a module sizes words, channels, the upstream FIFO or the register file
// ---------------------------------------------------------------------

`ifndef HARNESS_MACROS_SVH
`define HARNESS_MACROS_SVH

// Host side word width, both pipe directions
`define WORD_W 32

// Periodic channel timers posting reports upstream
`define NUM_CHAN 4

// Upstream FIFO entries, keep a power of two
`define UP_FIFO_DEPTH 64

// Configuration registers 0..30 are stored
`define NUM_REGS 31

// Register id used as a no-op target, never stored
`define NOP_REG 31

`endif

//--- verilog/hostCommandUnit.sv
// ---------------------------------------------------------------------
// Downstream word decoder. Holds the configuration registers, drives
// to-chip messages, channel writes and the decoder upstream path
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`include "harness_macros.svh"

module hostCommandUnit (
  input  logic                  okClk,
  input  logic                  rstN,
  input  logic                  pipeInValid,
  input  harnessPkg::hostWordT  pipeInData,
  output logic                  bdValid,
  output harnessPkg::bdCodeT    bdCode,
  output harnessPkg::bdPayloadT bdPayload,
  output logic                  upValid,
  output harnessPkg::hostWordT  upWord,
  output logic [3:0]            led,
  cmdIf.cmd                     cmd
);
  import harnessPkg::*;

  regDataT  regs [`NUM_REGS];  // Configuration registers 0..30
  wordKindE kind;              // Kind of the incoming word
  regIdT    wordId;            // Register or channel id field
  logic     echoEn;            // Register 1 bit 0, echo to-chip words upstream

  assign kind   = kindOf(pipeInData);
  assign wordId = pipeInData[28:24];  // Bit 29 is zero in reg and chan words
  assign echoEn = regs[1][0];
  assign led    = regs[0][3:0];       // LEDs follow register 0

  // ---------------------------------------------------------------------
  // Strobes and configuration registers
  // ---------------------------------------------------------------------
  always_ff @(posedge okClk) begin
    if (!rstN) begin
      bdValid       <= 1'b0;
      upValid       <= 1'b0;
      cmd.chanWrite <= 1'b0;
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      bdValid       <= pipeInValid && (kind == KindBd);
      cmd.chanWrite <= pipeInValid && (kind == KindChan);
      // From-chip words always go up, to-chip words only when echo is on
      upValid       <= pipeInValid &&
                       ((kind == KindFromBd) || ((kind == KindBd) && echoEn));

      // Register 31 is the no-op slot
      if (pipeInValid && (kind == KindReg) && (wordId != regIdT'(`NOP_REG))) begin
        regs[wordId] <= pipeInData[15:0];
      end
    end
  end

  // ---------------------------------------------------------------------
  // Payload fields, qualified by the strobes above
  // ---------------------------------------------------------------------
  always_ff @(posedge okClk) begin
    if (pipeInValid) begin
      bdCode        <= pipeInData[29:24];  // Code sits above 4 spare bits
      bdPayload     <= pipeInData[19:0];
      upWord        <= pipeInData;         // Forwarded unchanged
      cmd.chanId    <= wordId;
      cmd.chanValue <= pipeInData[15:0];
    end
  end

endmodule

//--- verilog/upstreamMerger.sv
// ---------------------------------------------------------------------
// Upstream path. Merges decoder words and channel reports into a
// show-ahead FIFO that the host drains with a read strobe
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`include "harness_macros.svh"

module upstreamMerger (
  input  logic                  okClk,
  input  logic                  rstN,
  input  logic                  upValid,
  input  harnessPkg::hostWordT  upWord,
  input  logic [`NUM_CHAN-1:0]  reportValid,
  input  harnessPkg::hostWordT  reportWord [`NUM_CHAN],
  output logic [`NUM_CHAN-1:0]  reportAck,
  input  logic                  pipeOutRead,
  output harnessPkg::hostWordT  pipeOutData,
  output logic                  pipeOutEmpty,
  output logic                  upOverflow
);
  import harnessPkg::*;

  localparam int ChW = (`NUM_CHAN > 1) ? $clog2(`NUM_CHAN) : 1;
  localparam int Aw  = $clog2(`UP_FIFO_DEPTH);

  // ---------------------------------------------------------------------
  // Arbiter
  // ---------------------------------------------------------------------
  logic [ChW-1:0] rrPtr;       // First channel looked at this cycle
  logic [ChW-1:0] grantIdx;    // Winning channel
  logic           grantValid;  // Some channel has a report pending
  logic           chanGo;      // Channel report is written this cycle
  logic           fifoFull;
  logic           fifoEmpty;
  logic           wrEn;
  logic           rdEn;
  hostWordT       wrData;

  // Rotating search starting at rrPtr
  always_comb begin
    int cand;
    cand       = 0;
    grantValid = 1'b0;
    grantIdx   = rrPtr;
    for (int k = 0; k < `NUM_CHAN; k++) begin
      cand = (int'(rrPtr) + k) % `NUM_CHAN;
      if (!grantValid && reportValid[cand]) begin
        grantValid = 1'b1;
        grantIdx   = ChW'(cand);
      end
    end
  end

  // Decoder word owns the write port, channels take idle cycles only
  assign chanGo = grantValid && !upValid && !fifoFull;
  assign wrEn   = (upValid && !fifoFull) || chanGo;
  assign wrData = upValid ? upWord : reportWord[grantIdx];

  always_comb begin
    reportAck = '0;
    if (chanGo) reportAck[grantIdx] = 1'b1;  // Single cycle ack
  end

  always_ff @(posedge okClk) begin
    if (!rstN) begin
      rrPtr      <= '0;
      upOverflow <= 1'b0;
    end else begin
      if (chanGo) begin
        // Winner goes to the back of the line
        rrPtr <= (grantIdx == ChW'(`NUM_CHAN - 1)) ? '0 : grantIdx + 1'b1;
      end
      if (upValid && fifoFull) upOverflow <= 1'b1;  // Sticky until reset
    end
  end

  // ---------------------------------------------------------------------
  // Show-ahead FIFO
  // ---------------------------------------------------------------------
  hostWordT       mem [`UP_FIFO_DEPTH];
  logic [Aw-1:0]  wrPtr;    // Depth is a power of two, pointers just wrap
  logic [Aw-1:0]  rdPtr;
  logic [Aw:0]    fillCnt;  // Entries held, 0..depth

  assign fifoFull     = (fillCnt == (Aw+1)'(`UP_FIFO_DEPTH));
  assign fifoEmpty    = (fillCnt == '0);
  assign rdEn         = pipeOutRead && !fifoEmpty;  // Read on empty is ignored
  assign pipeOutEmpty = fifoEmpty;
  assign pipeOutData  = mem[rdPtr];                 // Head word, valid when not empty

  always_ff @(posedge okClk) begin
    if (!rstN) begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      fillCnt <= '0;
    end else begin
      if (wrEn) wrPtr <= wrPtr + 1'b1;
      if (rdEn) rdPtr <= rdPtr + 1'b1;
      case ({wrEn, rdEn})
        2'b10:   fillCnt <= fillCnt + 1'b1;
        2'b01:   fillCnt <= fillCnt - 1'b1;
        default: fillCnt <= fillCnt;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge okClk) begin
    if (wrEn) mem[wrPtr] <= wrData;
  end

endmodule
